//--- logic/axi_bram_pkg.sv
package axi_bram_pkg;

  // =========================================================================
  // widths and fixed configuration
  // =========================================================================
  localparam int ADDR_W      = 12;
  localparam int DATA_W      = 32;
  localparam int ID_W        = 4;
  localparam int WORD_ADDR_W = 10;

  // largest encoded transfer size, 4 bytes on a 32-bit bus
  localparam logic [2:0] MAX_SIZE = 3'd2;

  // =========================================================================
  // encodings
  // =========================================================================
  // RSVD is handled like INCR
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,
    RSVD  = 2'b11
  } burst_e;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    BURST = 2'b01,
    DRAIN = 2'b10
  } rd_state_e;

  typedef logic [7:0] ar_len_t;

  // one AR request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    ar_len_t           len;
    logic [2:0]        size;
    burst_e            burst;
    logic [ID_W-1:0]   id;
  } ar_req_t;

  // one R beat, no RRESP
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic              last;
  } r_beat_t;

endpackage

//--- logic/axi_rd_ctrl_fsm.sv
`timescale 1ns/1ps

module axi_rd_ctrl_fsm (
  input  logic S_ACLK,
  input  logic S_ARESETN,
  input  logic ar_valid,
  input  logic r_ready,
  input  logic final_beat,
  output logic ar_ready,
  output logic addr_load,
  output logic rd_en,
  output logic r_valid
);
  import axi_bram_pkg::*;

  rd_state_e state_q;
  rd_state_e state_d;

  // output register can take a new beat this cycle
  logic out_free;
  logic r_hs;

  assign out_free = !r_valid || r_ready;
  assign r_hs     = r_valid && r_ready;

  // =========================================================================
  // strobes
  // =========================================================================
  assign ar_ready  = (state_q == IDLE);
  assign addr_load = ar_ready && ar_valid;

  // first read goes out in the handshake cycle itself
  assign rd_en = addr_load || ((state_q == BURST) && out_free);

  // =========================================================================
  // next state
  // =========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (addr_load) begin
          // single-beat burst has nothing left to issue
          state_d = final_beat ? DRAIN : BURST;
        end
      end
      BURST: begin
        if (rd_en && final_beat) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // the beat held now is the one carrying last
        if (r_hs) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // valid follows the RAM output register
  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      r_valid <= 1'b0;
    end else if (rd_en) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

endmodule

//--- logic/axi_rd_addr_gen.sv
`timescale 1ns/1ps

module axi_rd_addr_gen (
  input  logic                                 S_ACLK,
  input  logic                                 S_ARESETN,
  input  axi_bram_pkg::ar_req_t                ar_req,
  input  logic                                 addr_load,
  input  logic                                 rd_en,
  output logic [axi_bram_pkg::WORD_ADDR_W-1:0] rd_addr,
  output logic                                 final_beat,
  output logic [axi_bram_pkg::ID_W-1:0]        r_id,
  output logic                                 r_last
);
  import axi_bram_pkg::*;

  // captured burst state
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] bytes_q;
  burst_e            burst_q;
  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] wrap_end_q;
  logic [ID_W-1:0]   id_q;
  ar_len_t           cnt_q;

  // decode of the incoming request
  logic [2:0]        req_size;
  logic [ADDR_W-1:0] req_bytes;
  logic [ADDR_W-1:0] req_beats;
  logic [ADDR_W-1:0] req_total;
  logic [ADDR_W-1:0] req_base;
  logic [ADDR_W-1:0] req_wrap_end;

  // state seen by the read issued this cycle
  logic [ADDR_W-1:0] cur_addr;
  logic [ADDR_W-1:0] cur_bytes;
  burst_e            cur_burst;
  logic [ADDR_W-1:0] cur_base;
  logic [ADDR_W-1:0] cur_wrap_end;
  logic [ID_W-1:0]   cur_id;
  ar_len_t           cur_cnt;
  logic [ADDR_W-1:0] next_addr;

  // =========================================================================
  // request decode
  // =========================================================================
  assign req_size  = (ar_req.size > MAX_SIZE) ? MAX_SIZE : ar_req.size;
  assign req_bytes = ADDR_W'(1) << req_size;
  assign req_beats = ADDR_W'(ar_req.len) + 1'b1;
  assign req_total = req_bytes * req_beats;

  // wrap window aligned to the total burst size
  assign req_base     = ar_req.addr & ~(req_total - 1'b1);
  assign req_wrap_end = req_base + req_total - req_bytes;

  // on the load cycle the incoming request bypasses the registers
  assign cur_addr     = addr_load ? ar_req.addr  : addr_q;
  assign cur_bytes    = addr_load ? req_bytes    : bytes_q;
  assign cur_burst    = addr_load ? ar_req.burst : burst_q;
  assign cur_base     = addr_load ? req_base     : base_q;
  assign cur_wrap_end = addr_load ? req_wrap_end : wrap_end_q;
  assign cur_id       = addr_load ? ar_req.id    : id_q;
  assign cur_cnt      = addr_load ? ar_req.len   : cnt_q;

  assign rd_addr    = cur_addr[ADDR_W-1 -: WORD_ADDR_W];
  assign final_beat = (cur_cnt == '0);

  // =========================================================================
  // address step
  // =========================================================================
  always_comb begin
    case (cur_burst)
      FIXED:   next_addr = cur_addr;
      WRAP:    next_addr = (cur_addr == cur_wrap_end) ? cur_base : cur_addr + cur_bytes;
      default: next_addr = cur_addr + cur_bytes;
    endcase
  end

  always_ff @(posedge S_ACLK) begin
    if (addr_load) begin
      bytes_q    <= req_bytes;
      burst_q    <= ar_req.burst;
      base_q     <= req_base;
      wrap_end_q <= req_wrap_end;
      id_q       <= ar_req.id;
    end
    if (rd_en) begin
      addr_q <= next_addr;
      r_id   <= cur_id;
    end
  end

  // beat counter and last tag in step with the RAM output
  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      cnt_q  <= '0;
      r_last <= 1'b0;
    end else if (rd_en) begin
      cnt_q  <= cur_cnt - 1'b1;
      r_last <= final_beat;
    end
  end

endmodule

//--- logic/bram_sp.sv
`timescale 1ns/1ps

module bram_sp (
  input  logic                                 S_ACLK,
  input  logic                                 wr_en,
  input  logic [axi_bram_pkg::WORD_ADDR_W-1:0] wr_addr,
  input  logic [axi_bram_pkg::DATA_W-1:0]      wr_data,
  input  logic                                 rd_en,
  input  logic [axi_bram_pkg::WORD_ADDR_W-1:0] rd_addr,
  output logic [axi_bram_pkg::DATA_W-1:0]      rd_data
);
  import axi_bram_pkg::*;

  logic [DATA_W-1:0] mem [0:(1 << WORD_ADDR_W)-1];

  // read-first on a same-word collision
  always_ff @(posedge S_ACLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // output register holds while rd_en is low
  always_ff @(posedge S_ACLK) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- logic/axi_bram_rd_top.sv
`timescale 1ns/1ps

module axi_bram_rd_top (
  input  logic                                 S_ACLK,
  input  logic                                 S_ARESETN,
  // AR channel
  input  axi_bram_pkg::ar_req_t                ar_req,
  input  logic                                 ar_valid,
  output logic                                 ar_ready,
  // R channel
  output axi_bram_pkg::r_beat_t                r_beat,
  output logic                                 r_valid,
  input  logic                                 r_ready,
  // preload port
  input  logic                                 mem_wr_en,
  input  logic [axi_bram_pkg::WORD_ADDR_W-1:0] mem_wr_addr,
  input  logic [axi_bram_pkg::DATA_W-1:0]      mem_wr_data
);
  import axi_bram_pkg::*;

  logic                   addr_load;
  logic                   rd_en;
  logic                   final_beat;
  logic [WORD_ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0]      rd_data;
  logic [ID_W-1:0]        r_id;
  logic                   r_last;

  // =========================================================================
  // control
  // =========================================================================
  axi_rd_ctrl_fsm u_fsm (
    .S_ACLK     (S_ACLK),
    .S_ARESETN  (S_ARESETN),
    .ar_valid   (ar_valid),
    .r_ready    (r_ready),
    .final_beat (final_beat),
    .ar_ready   (ar_ready),
    .addr_load  (addr_load),
    .rd_en      (rd_en),
    .r_valid    (r_valid)
  );

  axi_rd_addr_gen u_addr (
    .S_ACLK     (S_ACLK),
    .S_ARESETN  (S_ARESETN),
    .ar_req     (ar_req),
    .addr_load  (addr_load),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .final_beat (final_beat),
    .r_id       (r_id),
    .r_last     (r_last)
  );

  // =========================================================================
  // storage
  // =========================================================================
  bram_sp u_mem (
    .S_ACLK  (S_ACLK),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // id and last are already aligned with rd_data
  assign r_beat = '{data: rd_data, id: r_id, last: r_last};

endmodule

//--- dv/tb_axi_bram_rd_util.svh
`ifndef TB_AXI_BRAM_RD_UTIL_SVH
`define TB_AXI_BRAM_RD_UTIL_SVH

// generator state and the image of the RAM after preload
logic [31:0]       lcg_state = 32'h67bb_f99b;
logic [DATA_W-1:0] model_mem [0:(1 << WORD_ADDR_W)-1];

// expected beats in order, and the len of each burst
r_beat_t exp_q[$];
ar_len_t len_q[$];

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic rand_bit();
  logic [31:0] v;
  v = lcg_next();
  return v[20];
endfunction

// expected beat sequence of one burst, from the AXI step rules
function automatic void ref_burst(ar_req_t req);
  r_beat_t beat;
  int      bytes;
  int      beats;
  int      total;
  int      base;
  int      addr;
  beats = int'(req.len) + 1;
  bytes = 1 << ((req.size > MAX_SIZE) ? MAX_SIZE : req.size);
  total = bytes * beats;
  addr  = int'(req.addr);
  base  = addr - (addr % total);
  for (int i = 0; i < beats; i++) begin
    beat.data = model_mem[(addr >> 2) % (1 << WORD_ADDR_W)];
    beat.id   = req.id;
    beat.last = (i == beats - 1);
    exp_q.push_back(beat);
    if (req.burst == WRAP) begin
      addr = addr + bytes;
      if (addr >= base + total) begin
        addr = base;
      end
    end else if (req.burst != FIXED) begin
      addr = (addr + bytes) % (1 << ADDR_W);
    end
  end
  len_q.push_back(req.len);
endfunction

`endif

//--- dv/tb_axi_bram_rd.sv
`timescale 1ns/1ps

module tb_axi_bram_rd;
  import axi_bram_pkg::*;

  localparam int CLK_HALF   = 10;
  localparam int RST_CYCLES = 10;

  logic                   S_ACLK;
  logic                   S_ARESETN;
  ar_req_t                ar_req;
  logic                   ar_valid;
  logic                   ar_ready;
  r_beat_t                r_beat;
  logic                   r_valid;
  logic                   r_ready;
  logic                   mem_wr_en;
  logic [WORD_ADDR_W-1:0] mem_wr_addr;
  logic [DATA_W-1:0]      mem_wr_data;

  // planned requests with their test name and ready mode
  ar_req_t req_q[$];
  string   name_q[$];
  bit      rnd_q[$];
  // names of bursts still owed beats
  string   active_q[$];

  int      total_beats = 0;
  int      value_errors = 0;
  int      proto_errors = 0;
  bit      random_ready = 1'b0;
  bit      busy = 1'b0;
  int      beat_cnt = 0;
  bit      hold_pending = 1'b0;
  r_beat_t hold_beat;

  `include "tb_axi_bram_rd_util.svh"

  axi_bram_rd_top u_dut (
    .S_ACLK      (S_ACLK),
    .S_ARESETN   (S_ARESETN),
    .ar_req      (ar_req),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r_beat      (r_beat),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data)
  );

  always #CLK_HALF S_ACLK = ~S_ACLK;

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_beat(input string name, input r_beat_t exp, input r_beat_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error [%s] beat: expected data %h id %h last %b, actual data %h id %h last %b",
               name, exp.data, exp.id, exp.last, act.data, act.id, act.last);
    end
  endtask

  task automatic check_len(input string name, input ar_len_t exp, input ar_len_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error [%s] len: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error [%s]: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic take_beat(input r_beat_t act);
    r_beat_t exp;
    ar_len_t exp_len;
    string   name;
    if (exp_q.size() == 0) begin
      proto_errors++;
      $display("an R beat arrived at %0t with no beat expected", $time);
      return;
    end
    name = (active_q.size() != 0) ? active_q[0] : "unknown";
    exp  = exp_q.pop_front();
    beat_cnt++;
    check_beat(name, exp, act);
    if (exp.last && !act.last) begin
      proto_errors++;
      $display("the final beat of %s at %0t came without last", name, $time);
    end
    if (exp.last || act.last) begin
      exp_len = len_q.pop_front();
      if (act.last) begin
        check_len(name, exp_len, ar_len_t'(beat_cnt - 1));
      end
      beat_cnt = 0;
      busy     = 1'b0;
      if (active_q.size() != 0) begin
        void'(active_q.pop_front());
      end
    end
  endtask

  // ==========================================================================
  // request planning
  // ==========================================================================
  task automatic add_req(input string name, input burst_e b, input logic [2:0] size,
                         input ar_len_t len, input bit rnd);
    ar_req_t     req;
    logic [31:0] v;
    int          bytes;
    int          total;
    int          a;
    v     = lcg_next();
    bytes = 1 << size;
    total = bytes * (int'(len) + 1);
    if (b == WRAP) begin
      a = int'(v[11:0]);
    end else begin
      // keep INCR inside the 4 KB space
      a = int'(v[23:0]) % (4096 - total);
    end
    req.addr  = ADDR_W'(a & ~(bytes - 1));
    req.len   = len;
    req.size  = size;
    req.burst = b;
    req.id    = v[31:28];
    req_q.push_back(req);
    name_q.push_back(name);
    rnd_q.push_back(rnd);
    total_beats += int'(len) + 1;
  endtask

  task automatic plan_tests();
    logic [31:0] v;
    burst_e      b;
    ar_len_t     len;
    for (int i = 0; i < 8; i++) begin
      add_req("incr_full", INCR, 3'd2, ar_len_t'(lcg_next() % 64), 1'b0);
    end
    // 2, 4, 8 and 16 beats, twice each
    for (int i = 0; i < 8; i++) begin
      add_req("wrap", WRAP, 3'd2, ar_len_t'((2 << (i % 4)) - 1), 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      add_req("fixed", FIXED, 3'd2, ar_len_t'(lcg_next() % 16), 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      add_req("incr_narrow", INCR, 3'(i % 2), ar_len_t'(lcg_next() % 32), 1'b0);
    end
    for (int i = 0; i < 12; i++) begin
      v   = lcg_next();
      b   = burst_e'(v[9:8]);
      len = (b == WRAP) ? ar_len_t'((2 << v[1:0]) - 1) : ar_len_t'(v[4:0]);
      add_req("rand_ready", b, 3'(v[13:12] % 3), len, 1'b1);
    end
  endtask

  // ==========================================================================
  // R ready and compare process
  // ==========================================================================
  always @(posedge S_ACLK) begin
    if (random_ready) begin
      r_ready <= rand_bit();
    end else begin
      r_ready <= 1'b1;
    end
  end

  always @(posedge S_ACLK) begin
    if (!S_ARESETN) begin
      if (ar_valid && ar_ready) begin
        if (busy) begin
          proto_errors++;
          $display("an AR was accepted at %0t before the last beat of a burst", $time);
        end
        busy = 1'b1;
      end
      // a stalled beat must stay put
      if (hold_pending) begin
        if (!r_valid) begin
          proto_errors++;
          $display("r_valid dropped at %0t while the beat was stalled", $time);
        end else begin
          check_beat("stall", hold_beat, r_beat);
        end
      end
      if (r_valid && r_ready) begin
        take_beat(r_beat);
      end
      hold_pending = r_valid && !r_ready;
      hold_beat    = r_beat;
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    ar_req_t     req;
    logic [31:0] v;
    S_ACLK      = 1'b0;
    S_ARESETN   = 1'b1;
    ar_req      = '0;
    ar_valid    = 1'b0;
    r_ready     = 1'b1;
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    plan_tests();

    repeat (RST_CYCLES) @(posedge S_ACLK);
    S_ARESETN <= 1'b0;
    @(negedge S_ACLK);
    check_flag("reset ar_ready", 1'b1, ar_ready);
    check_flag("reset r_valid", 1'b0, r_valid);

    // preload every word and mirror it
    for (int w = 0; w < (1 << WORD_ADDR_W); w++) begin
      @(posedge S_ACLK);
      v            = lcg_next();
      model_mem[w] = v;
      mem_wr_en   <= 1'b1;
      mem_wr_addr <= WORD_ADDR_W'(w);
      mem_wr_data <= v;
    end
    @(posedge S_ACLK);
    mem_wr_en <= 1'b0;

    while (req_q.size() != 0) begin
      req = req_q.pop_front();
      active_q.push_back(name_q.pop_front());
      ref_burst(req);
      @(posedge S_ACLK);
      random_ready <= rnd_q.pop_front();
      ar_req       <= req;
      ar_valid     <= 1'b1;
      do @(posedge S_ACLK); while (!ar_ready);
      ar_valid <= 1'b0;
    end

    while (exp_q.size() != 0 || busy) @(negedge S_ACLK);
    repeat (4) @(posedge S_ACLK);

    $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (total_beats > 0);
    repeat (total_beats * 8 + 2000) @(posedge S_ACLK);
    $display("timeout: the run did not finish within %0d cycles", total_beats * 8 + 2000);
    $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    $display("Something failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+dv
logic/axi_bram_pkg.sv
logic/axi_rd_ctrl_fsm.sv
logic/axi_rd_addr_gen.sv
logic/bram_sp.sv
logic/axi_bram_rd_top.sv
dv/tb_axi_bram_rd.sv
